/* ex_mem_wb_pipe.f */
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/execute_stage.sv
rtl/execute_memory_latch.sv
rtl/memory_stage.sv
rtl/ex_mem_wb_pipe.sv
testbench/tb_ex_mem_wb_pipe.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in the log.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --timescale 1ns/1ns \
    -f ex_mem_wb_pipe.f \
    --top-module tb_ex_mem_wb_pipe \
    --Mdir "$build_dir" \
    -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/sim_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ $sim_status -eq 0 ] && grep -qx "=== PASS ===" "$log_file"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed (exit status $sim_status)"
    exit 1
fi

/* testbench/tb_ex_mem_wb_pipe.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_macros.svh"

module tb_ex_mem_wb_pipe;

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int CLK_PERIOD  = 10;
    localparam int N_PRELOAD   = `DMEM_DEPTH;
    localparam int N_ALU       = 240;
    localparam int N_PAIR      = 40;
    localparam int N_MISALIGN  = 20;
    localparam int N_CTRL      = 12;
    // Pair, misalignment and control groups issue three slots each.
    localparam int TOTAL_SLOTS = N_PRELOAD + N_ALU + 3 * (N_PAIR + N_MISALIGN + N_CTRL);

    logic       clk;
    logic       arst_n;
    decoded_t   dec_in;
    wb_bundle_t wb_out;

    integer     seed;
    word_t      model_mem [`DMEM_DEPTH];
    wb_bundle_t exp_q [$];
    int         issue_q [$];
    int         edge_cnt;
    int         issued;
    int         checked;

    ex_mem_wb_pipe dut0 (
        .clk    (clk),
        .arst_n (arst_n),
        .dec_in (dec_in),
        .wb_out (wb_out)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    function automatic word_t rand16();
        return word_t'($random(seed));
    endfunction

    // Expected writeback for one slot. Aligned stores update the model memory in issue order.
    function automatic wb_bundle_t predict_wb(input decoded_t d);
        wb_bundle_t                 r;
        word_t                      b;
        word_t                      alu;
        logic                       misaligned;
        logic [`DMEM_ADDR_BITS-1:0] idx;
        if (!d.valid) begin
            r.reg_write     = 1'b0;
            r.write_reg_sel = reg_sel_t'(`BUBBLE_FILL);
            r.write_data    = `BUBBLE_FILL;
            r.halt          = 1'b0;
            r.align_err     = 1'b0;
            r.instruction   = `BUBBLE_INSTR;
        end else begin
            b = d.ctrl.use_imm ? d.imm_ext : d.read2_data;
            case (d.ctrl.alu_op)
                ADD:     alu = d.read1_data + b;
                SUB:     alu = d.read1_data - b;
                AND:     alu = d.read1_data & b;
                OR:      alu = d.read1_data | b;
                XOR:     alu = d.read1_data ^ b;
                SLL:     alu = d.read1_data << b[3:0];
                SRL:     alu = d.read1_data >> b[3:0];
                default: alu = b;
            endcase
            misaligned = (d.ctrl.mem_read | d.ctrl.mem_write) & alu[0];
            idx = alu[`DMEM_ADDR_BITS:1];
            if (d.ctrl.link) begin
                r.write_data = d.pc + word_t'(2);
            end else if (d.ctrl.mem_to_reg) begin
                r.write_data = model_mem[idx];
            end else begin
                r.write_data = alu;
            end
            if (d.ctrl.mem_write && !misaligned) begin
                model_mem[idx] = d.read2_data;
            end
            r.reg_write     = d.ctrl.reg_write & ~(d.ctrl.mem_read & misaligned);
            r.write_reg_sel = d.write_reg_sel;
            r.halt          = d.ctrl.halt;
            r.align_err     = misaligned;
            r.instruction   = d.instruction;
        end
        return r;
    endfunction

    function automatic decoded_t random_slot();
        decoded_t d;
        d.valid         = 1'b1;
        d.pc            = rand16();
        d.instruction   = rand16();
        d.read1_data    = rand16();
        d.read2_data    = rand16();
        d.imm_ext       = rand16();
        d.write_reg_sel = reg_sel_t'(rand16());
        d.ctrl          = '0;
        return d;
    endfunction

    // About one slot in eight comes out empty.
    function automatic decoded_t alu_slot(input alu_op_e op);
        decoded_t d;
        word_t    r;
        d = random_slot();
        r = rand16();
        d.valid          = (r[3:1] != 3'd0);
        d.ctrl.use_imm   = r[0];
        d.ctrl.reg_write = 1'b1;
        d.ctrl.alu_op    = op;
        return d;
    endfunction

    task automatic issue(input decoded_t d);
        @(posedge clk);
        dec_in <= d;
        exp_q.push_back(predict_wb(d));
        issue_q.push_back(edge_cnt + 1);
        issued++;
    endtask

    // The address is formed as base plus immediate, so the ALU builds it.
    task automatic mem_access(input logic is_store, input word_t addr, input word_t data);
        decoded_t d;
        d = random_slot();
        d.imm_ext          = addr - d.read1_data;
        d.read2_data       = data;
        d.ctrl.use_imm     = 1'b1;
        d.ctrl.alu_op      = ADD;
        d.ctrl.mem_write   = is_store;
        d.ctrl.mem_read    = ~is_store;
        d.ctrl.mem_to_reg  = ~is_store;
        d.ctrl.reg_write   = ~is_store;
        issue(d);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_sel(input string name, input reg_sel_t exp, input reg_sel_t act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic compare_wb(input wb_bundle_t exp);
        check_bit("wb_out.reg_write", exp.reg_write, wb_out.reg_write);
        check_sel("wb_out.write_reg_sel", exp.write_reg_sel, wb_out.write_reg_sel);
        check_word("wb_out.write_data", exp.write_data, wb_out.write_data);
        check_bit("wb_out.halt", exp.halt, wb_out.halt);
        check_bit("wb_out.align_err", exp.align_err, wb_out.align_err);
        check_word("wb_out.instruction", exp.instruction, wb_out.instruction);
    endtask

    // Each slot is due two rising edges after it was issued.
    always @(negedge clk) begin
        wb_bundle_t exp_wb;
        if (exp_q.size() != 0 && edge_cnt == issue_q[0] + 2) begin
            exp_wb = exp_q.pop_front();
            void'(issue_q.pop_front());
            compare_wb(exp_wb);
            checked++;
        end
    end

    initial begin
        logic [`DMEM_ADDR_BITS-1:0] idx;
        word_t                      r;
        word_t                      addr;
        decoded_t                   d;
        seed = 32'heccc_ab86;
        arst_n <= 1'b0;
        dec_in <= '0;
        @(negedge clk);
        compare_wb(predict_wb('0));
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        compare_wb(predict_wb('0));

        // Every word gets a known value before any load.
        for (int i = 0; i < N_PRELOAD; i++) begin
            idx = i[7:0];
            r = rand16();
            mem_access(1'b1, {r[6:0], idx, 1'b0}, {idx ^ 8'h5a, ~idx});
        end
        for (int i = 0; i < N_ALU; i++) begin
            issue(alu_slot(alu_op_e'(i[2:0])));
        end
        for (int i = 0; i < N_PAIR; i++) begin
            addr = rand16() & 16'hfffe;
            mem_access(1'b1, addr, rand16());
            mem_access(1'b0, addr, rand16());
            mem_access(1'b0, rand16() & 16'hfffe, rand16());
        end
        for (int i = 0; i < N_MISALIGN; i++) begin
            addr = rand16() | 16'h0001;
            mem_access(1'b1, addr, rand16());
            mem_access(1'b0, addr, rand16());
            mem_access(1'b0, addr & 16'hfffe, rand16());
        end
        for (int i = 0; i < N_CTRL; i++) begin
            d = random_slot();
            d.ctrl.link      = 1'b1;
            d.ctrl.reg_write = 1'b1;
            issue(d);
            d = random_slot();
            d.ctrl.halt = 1'b1;
            issue(d);
            d = random_slot();
            d.valid = 1'b0;
            issue(d);
        end

        while (checked != issued) @(posedge clk);
        $display("=== PASS ===");
        $finish;
    end

    initial begin
        #((TOTAL_SLOTS + 20) * CLK_PERIOD);
        $display("Timeout with %0d of %0d results checked.", checked, issued);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* rtl/ex_mem_wb_pipe.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_mem_wb_pipe (
    input  logic                 clk,
    input  logic                 arst_n,
    input  pipe_pkg::decoded_t   dec_in,
    output pipe_pkg::wb_bundle_t wb_out
);

    import pipe_pkg::*;

    em_bundle_t ex_out;
    em_bundle_t em;
    logic       nop;

    // An empty slot from decode enters the pipeline as a bubble.
    assign nop = ~dec_in.valid;

    execute_stage execute_stage0 (
        .dec    (dec_in),
        .ex_out (ex_out)
    );

    execute_memory_latch execute_memory_latch0 (
        .clk    (clk),
        .arst_n (arst_n),
        .nop    (nop),
        .ex_in  (ex_out),
        .em     (em)
    );

    memory_stage memory_stage0 (
        .clk    (clk),
        .arst_n (arst_n),
        .em     (em),
        .wb_out (wb_out)
    );

endmodule

`default_nettype wire

/* rtl/memory_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_macros.svh"

module memory_stage (
    input  logic                 clk,
    input  logic                 arst_n,
    input  pipe_pkg::em_bundle_t em,
    output pipe_pkg::wb_bundle_t wb_out
);

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam wb_bundle_t wb_bubble = '{
        reg_write:     1'b0,
        write_reg_sel: reg_sel_t'(`BUBBLE_FILL),
        write_data:    `BUBBLE_FILL,
        halt:          1'b0,
        align_err:     1'b0,
        instruction:   `BUBBLE_INSTR
    };

    word_t                      dmem [`DMEM_DEPTH];
    logic [`DMEM_ADDR_BITS-1:0] dmem_idx;
    word_t                      mem_rdata;
    word_t                      link_addr;
    word_t                      wb_data;
    logic                       wb_reg_write;
    wb_bundle_t                 wb_next;

    // Byte address bit 0 is dropped to form the word index.
    assign dmem_idx  = em.alu_out[`DMEM_ADDR_BITS:1];
    assign mem_rdata = dmem[dmem_idx];

    // Misaligned stores are dropped so memory keeps its old word.
    always_ff @(posedge clk) begin
        if (em.mem_write && !em.align_err) begin
            dmem[dmem_idx] <= em.read2_data;
        end
    end

    assign link_addr = em.pc + word_t'(2);

    always_comb begin
        if (em.link) begin
            wb_data = link_addr;
        end else if (em.mem_to_reg) begin
            wb_data = mem_rdata;
        end else begin
            wb_data = em.alu_out;
        end
    end

    // a misaligned load has no valid data to write back
    assign wb_reg_write = em.reg_write & ~(em.mem_read & em.align_err);

    always_comb begin
        wb_next.reg_write     = wb_reg_write;
        wb_next.write_reg_sel = em.write_reg_sel;
        wb_next.write_data    = wb_data;
        wb_next.halt          = em.halt;
        wb_next.align_err     = em.align_err;
        wb_next.instruction   = em.instruction;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_out <= wb_bubble;
        end else begin
            wb_out <= wb_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/execute_memory_latch.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_macros.svh"

module execute_memory_latch (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 nop,
    input  pipe_pkg::em_bundle_t ex_in,
    output pipe_pkg::em_bundle_t em
);

    import isa_pkg::*;
    import pipe_pkg::*;

    // A bubble does nothing downstream. All control bits are low.
    localparam em_bundle_t em_bubble = '{
        pc:            `BUBBLE_FILL,
        instruction:   `BUBBLE_INSTR,
        alu_out:       `BUBBLE_FILL,
        read2_data:    `BUBBLE_FILL,
        write_reg_sel: reg_sel_t'(`BUBBLE_FILL),
        mem_read:      1'b0,
        mem_write:     1'b0,
        mem_to_reg:    1'b0,
        reg_write:     1'b0,
        link:          1'b0,
        halt:          1'b0,
        align_err:     1'b0
    };

    em_bundle_t em_next;

    assign em_next = nop ? em_bubble : ex_in;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            em <= em_bubble;
        end else begin
            em <= em_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  pipe_pkg::decoded_t   dec,
    output pipe_pkg::em_bundle_t ex_out
);

    import isa_pkg::*;
    import pipe_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_res;
    logic  mem_access;

    assign op_a = dec.read1_data;

    // Immediate forms replace the second register operand.
    assign op_b = dec.ctrl.use_imm ? dec.imm_ext : dec.read2_data;

    always_comb begin
        case (dec.ctrl.alu_op)
            ADD:     alu_res = op_a + op_b;
            SUB:     alu_res = op_a - op_b;
            AND:     alu_res = op_a & op_b;
            OR:      alu_res = op_a | op_b;
            XOR:     alu_res = op_a ^ op_b;
            // Shift amount comes from the low four bits only.
            SLL:     alu_res = op_a << op_b[3:0];
            SRL:     alu_res = op_a >> op_b[3:0];
            PASS_B:  alu_res = op_b;
            default: alu_res = op_b;
        endcase
    end

    assign mem_access = dec.ctrl.mem_read | dec.ctrl.mem_write;

    always_comb begin
        ex_out.pc            = dec.pc;
        ex_out.instruction   = dec.instruction;
        ex_out.alu_out       = alu_res;
        ex_out.read2_data    = dec.read2_data;
        ex_out.write_reg_sel = dec.write_reg_sel;
        ex_out.mem_read      = dec.ctrl.mem_read;
        ex_out.mem_write     = dec.ctrl.mem_write;
        ex_out.mem_to_reg    = dec.ctrl.mem_to_reg;
        ex_out.reg_write     = dec.ctrl.reg_write;
        ex_out.link          = dec.ctrl.link;
        ex_out.halt          = dec.ctrl.halt;
        // Memory is word addressed, so an odd byte address cannot be served.
        ex_out.align_err     = mem_access & alu_res[0];
    end

endmodule

`default_nettype wire

/* rtl/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    // Control bits produced by decode.
    typedef struct packed {
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    reg_write;
        logic    link;
        logic    halt;
        logic    use_imm;
        alu_op_e alu_op;
    } ctrl_t;

    // One decoded instruction with its operands already resolved.
    typedef struct packed {
        logic     valid;
        word_t    pc;
        instr_t   instruction;
        word_t    read1_data;
        word_t    read2_data;
        word_t    imm_ext;
        reg_sel_t write_reg_sel;
        ctrl_t    ctrl;
    } decoded_t;

    // What execute hands to the memory stage.
    typedef struct packed {
        word_t    pc;
        instr_t   instruction;
        word_t    alu_out;
        word_t    read2_data;
        reg_sel_t write_reg_sel;
        logic     mem_read;
        logic     mem_write;
        logic     mem_to_reg;
        logic     reg_write;
        logic     link;
        logic     halt;
        logic     align_err;
    } em_bundle_t;

    // Writeback result leaving the pipeline.
    typedef struct packed {
        logic     reg_write;
        reg_sel_t write_reg_sel;
        word_t    write_data;
        logic     halt;
        logic     align_err;
        instr_t   instruction;
    } wb_bundle_t;

endpackage

`default_nettype wire

/* rtl/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    // Machine word and instruction word are both 16 bits wide in this ISA.
    typedef logic [15:0] word_t;
    typedef logic [15:0] instr_t;

    // Sixteen architectural registers.
    typedef logic [3:0]  reg_sel_t;

    // ALU operations as issued by decode.
    typedef enum logic [2:0] {
        ADD    = 3'd0,
        SUB    = 3'd1,
        AND    = 3'd2,
        OR     = 3'd3,
        XOR    = 3'd4,
        SLL    = 3'd5,
        SRL    = 3'd6,
        PASS_B = 3'd7
    } alu_op_e;

endpackage

`default_nettype wire

/* rtl/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// The data memory is indexed by word, so byte address bit 0 is not part of the index.
`define DMEM_ADDR_BITS 8
`define DMEM_DEPTH     (1 << `DMEM_ADDR_BITS)

// A bubble carries the NOP encoding.
`define BUBBLE_INSTR   16'b0000_1000_0000_0000

// Data fields of a bubble are filled with all ones so they stand out in waveforms.
`define BUBBLE_FILL    16'hffff

`endif
